//--- Bender.yml
package:
  name: face_detection_ip

sources:
  - include_dirs:
      - .
    files:
      - fd_pkg.sv
      - fd_stream_if.sv
      - fd_host_bridge.sv
      - fd_tile_accum.sv
      - fd_tile_classify.sv
      - fd_seg7_display.sv
      - face_detection_ip.sv
      - target: test
        files:
          - tb_clock_gen.sv
          - tb_face_detection.sv

//--- face_detection_ip.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module face_detection_ip
(
	input  logic                        s_clk,
	input  logic                        rst_n,
	input  logic [`FD_ADDR_WIDTH-1:0]   s_address,
	input  logic                        s_read,
	output logic [7:0]                  s_readdata,
	input  logic                        s_write,
	input  logic [7:0]                  s_writedata,
	output logic [`FD_SEG7_DIGITS*8-1:0] SEG7
);

	fd_pkg::pixel_t  band_lo;
	fd_pkg::pixel_t  band_hi;
	fd_pkg::result_t result;
	logic            soft_clear;

	// Pixels from bridge to accumulator
	fd_stream_if #(.payload_t(fd_pkg::pixel_t)) pix_if ();
	// Tile scores from accumulator to classifier
	fd_stream_if #(.payload_t(fd_pkg::score_t)) score_if ();

	// Host registers and pixel source
	fd_host_bridge u_bridge
	(
		.s_clk       (s_clk),
		.rst_n       (rst_n),
		.s_address   (s_address),
		.s_read      (s_read),
		.s_write     (s_write),
		.s_writedata (s_writedata),
		.s_readdata  (s_readdata),
		.pix         (pix_if.src),
		.result      (result),
		.band_lo     (band_lo),
		.band_hi     (band_hi),
		.soft_clear  (soft_clear)
	);

	fd_tile_accum u_accum
	(
		.s_clk      (s_clk),
		.rst_n      (rst_n),
		.soft_clear (soft_clear),
		.pix        (pix_if.snk),
		.score      (score_if.src)
	);

	fd_tile_classify u_classify
	(
		.s_clk      (s_clk),
		.rst_n      (rst_n),
		.soft_clear (soft_clear),
		.score      (score_if.snk),
		.band_lo    (band_lo),
		.band_hi    (band_hi),
		.result     (result)
	);

	// Hit count on the display
	fd_seg7_display u_seg7
	(
		.hits (result.hits),
		.seg7 (SEG7)
	);

endmodule

//--- fd_golden.txt
# name band_lo band_hi, then 64 pixels in two rows of 32 (8 per tile), all hex
# closing row: expected hit count and first hit tile index (FF when no tile hits)
band_mid 80 A0
0F 11 0F 11 10 10 10 10 4F 51 4F 51 50 50 50 50 7F 81 7F 81 80 80 80 80 8F 91 8F 91 90 90 90 90
9F A1 9F A1 A0 A0 A0 A0 A0 A2 A0 A2 A1 A1 A1 A1 80 80 80 80 80 80 80 7F 94 96 94 96 95 95 95 95
04 02
no_hit C0 D0
1F 21 1F 21 20 20 20 20 3F 41 3F 41 40 40 40 40 5F 61 5F 61 60 60 60 60 C0 C0 C0 C0 C0 C0 C0 BF
D0 D2 D0 D2 D1 D1 D1 D1 DF E1 DF E1 E0 E0 E0 E0 FF FF FF FF FF FF FF FF 00 00 00 00 00 00 00 00
00 FF
all_hit 00 FF
00 04 08 0C 10 14 18 1C 20 24 28 2C 30 34 38 3C 40 44 48 4C 50 54 58 5C 60 64 68 6C 70 74 78 7C
80 84 88 8C 90 94 98 9C A0 A4 A8 AC B0 B4 B8 BC C0 C4 C8 CC D0 D4 D8 DC E0 E4 E8 EC F0 F4 F8 FC
08 00
last_tile 30 3F
2E 30 2E 30 2F 2F 2F 2F 3F 41 3F 41 40 40 40 40 30 30 30 30 30 30 30 2F 3F 41 3F 41 40 40 40 40
2E 30 2E 30 2F 2F 2F 2F 3F 41 3F 41 40 40 40 40 40 40 40 40 40 40 40 40 3E 40 3E 40 3F 3F 3F 3F
01 07

//--- fd_host_bridge.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module fd_host_bridge
(
	input  logic                      s_clk,
	input  logic                      rst_n,
	input  logic [`FD_ADDR_WIDTH-1:0] s_address,
	input  logic                      s_read,
	input  logic                      s_write,
	input  fd_pkg::pixel_t            s_writedata,
	output logic [7:0]                s_readdata,
	fd_stream_if.src                  pix,
	input  fd_pkg::result_t           result,
	output fd_pkg::pixel_t            band_lo,
	output fd_pkg::pixel_t            band_hi,
	output logic                      soft_clear
);

	localparam int CNT_W = $clog2(`FD_FRAME_PIXELS);

	logic             wr_ctrl;
	logic             wr_pixel;
	logic             wr_band_lo;
	logic             wr_band_hi;
	logic             cmd_reset;
	logic             cmd_start;
	logic             frame_open;
	logic             dropped;
	logic [CNT_W-1:0] pix_cnt;
	logic             pend_valid;
	logic             pend_last;
	fd_pkg::pixel_t   pend_data;
	logic             slot_free;
	logic             pix_take;
	logic             pix_fire;

	// Host write decode
	assign wr_ctrl    = s_write && (s_address == fd_pkg::REG_CTRL);
	assign wr_pixel   = s_write && (s_address == fd_pkg::REG_PIXEL);
	assign wr_band_lo = s_write && (s_address == fd_pkg::REG_BAND_LO);
	assign wr_band_hi = s_write && (s_address == fd_pkg::REG_BAND_HI);

	// Soft reset wins when both control bits are set
	assign cmd_reset  = wr_ctrl && s_writedata[0];
	assign cmd_start  = wr_ctrl && s_writedata[1] && !s_writedata[0];
	assign soft_clear = cmd_reset || cmd_start;

	// Holding register drains this cycle or is empty
	assign pix_fire  = pend_valid && pix.ready;
	assign slot_free = !pend_valid || pix.ready;
	// Nothing more enters once the frame's last pixel is pending
	assign pix_take  = wr_pixel && frame_open && slot_free && !(pend_valid && pend_last);

	// Frame control and pixel holding register
	always_ff @(posedge s_clk)
	begin
		if (!rst_n || cmd_reset)
		begin
			frame_open <= 1'b0;
			dropped    <= 1'b0;
			pix_cnt    <= '0;
			pend_valid <= 1'b0;
			pend_last  <= 1'b0;
		end
		else if (cmd_start)
		begin
			frame_open <= 1'b1;
			dropped    <= 1'b0;
			pix_cnt    <= '0;
			pend_valid <= 1'b0;
			pend_last  <= 1'b0;
		end
		else
		begin
			if (pix_take)
			begin
				pend_valid <= 1'b1;
				// Tag the final pixel of the frame
				pend_last  <= (pix_cnt == CNT_W'(`FD_FRAME_PIXELS - 1));
				pix_cnt    <= pix_cnt + 1'b1;
			end
			else if (pix_fire)
			begin
				pend_valid <= 1'b0;
			end
			// Sticky until the next start or reset
			if (wr_pixel && !pix_take)
				dropped <= 1'b1;
			// Frame closes when the stream takes the last pixel
			if (pix_fire && pend_last)
				frame_open <= 1'b0;
		end
	end

	// Pixel payload
	always_ff @(posedge s_clk)
	begin
		if (pix_take)
			pend_data <= s_writedata;
	end

	assign pix.valid = pend_valid;
	assign pix.data  = pend_data;
	assign pix.last  = pend_last;

	// Skin-tone band, full range out of reset
	always_ff @(posedge s_clk)
	begin
		if (!rst_n)
		begin
			band_lo <= 8'h00;
			band_hi <= 8'hFF;
		end
		else
		begin
			if (wr_band_lo)
				band_lo <= s_writedata;
			if (wr_band_hi)
				band_hi <= s_writedata;
		end
	end

	// Read data, one cycle after s_read
	always_ff @(posedge s_clk)
	begin
		if (s_read)
		begin
			case (fd_pkg::reg_addr_e'(s_address))
				fd_pkg::REG_STATUS:  s_readdata <= {5'b0, dropped, result.done, frame_open};
				fd_pkg::REG_HITS:    s_readdata <= result.hits;
				fd_pkg::REG_FIRST:   s_readdata <= result.first;
				fd_pkg::REG_BAND_LO: s_readdata <= band_lo;
				fd_pkg::REG_BAND_HI: s_readdata <= band_hi;
				// Write-only registers read as zero
				default:             s_readdata <= 8'h00;
			endcase
		end
	end

endmodule

//--- fd_pkg.sv
`include "fd_settings.svh"

package fd_pkg;

	// One grey-level pixel from the host
	typedef logic [7:0] pixel_t;

	// Tile sum, pixel width plus log2 of the tile length
	typedef logic [7+$clog2(`FD_TILE_PIXELS):0] score_t;

	// Tile position inside a frame, all ones means no hit
	typedef logic [7:0] tile_idx_t;

	// Host register map
	typedef enum logic [`FD_ADDR_WIDTH-1:0] {
		REG_CTRL    = 'd0,
		REG_PIXEL   = 'd1,
		REG_STATUS  = 'd2,
		REG_HITS    = 'd3,
		REG_FIRST   = 'd4,
		REG_BAND_LO = 'd5,
		REG_BAND_HI = 'd6
	} reg_addr_e;

	// Classifier outcome for the current frame
	typedef struct packed {
		logic [7:0] hits;
		tile_idx_t  first;
		logic       done;
	} result_t;

endpackage

//--- fd_seg7_display.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module fd_seg7_display
(
	input  logic [7:0]                  hits,
	output logic [`FD_SEG7_DIGITS*8-1:0] seg7
);

	localparam int NIB_W = `FD_SEG7_DIGITS * 4;

	logic [NIB_W-1:0] nibbles;

	// Segment a at bit 0 up to g at bit 6
	function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
		case (nib)
			4'h0: hex_to_seg = 7'h3F;
			4'h1: hex_to_seg = 7'h06;
			4'h2: hex_to_seg = 7'h5B;
			4'h3: hex_to_seg = 7'h4F;
			4'h4: hex_to_seg = 7'h66;
			4'h5: hex_to_seg = 7'h6D;
			4'h6: hex_to_seg = 7'h7D;
			4'h7: hex_to_seg = 7'h07;
			4'h8: hex_to_seg = 7'h7F;
			4'h9: hex_to_seg = 7'h6F;
			4'hA: hex_to_seg = 7'h77;
			4'hB: hex_to_seg = 7'h7C;
			4'hC: hex_to_seg = 7'h39;
			4'hD: hex_to_seg = 7'h5E;
			4'hE: hex_to_seg = 7'h79;
			default: hex_to_seg = 7'h71;
		endcase
	endfunction

	// Fit the count to the digit count
	assign nibbles = NIB_W'(hits);

	// Digit 0 shows the low nibble
	for (genvar d = 0; d < `FD_SEG7_DIGITS; d++)
	begin : g_digit
		logic [7:0] raw;
		// Decimal point stays dark
		assign raw = {1'b0, hex_to_seg(nibbles[d*4 +: 4])};
		assign seg7[d*8 +: 8] = `FD_SEG7_LOW_ACTIVE ? ~raw : raw;
	end

endmodule

//--- fd_settings.svh
`ifndef FD_SETTINGS_SVH
`define FD_SETTINGS_SVH

// Frame geometry in pixels
`define FD_FRAME_PIXELS 64

// Pixels summed into one tile score
// Must divide the frame length
`define FD_TILE_PIXELS 8

// Host register address width
`define FD_ADDR_WIDTH 3

// Seven-segment digits driven by the hit counter
`define FD_SEG7_DIGITS 2

// Segments lit by a low level when set
`define FD_SEG7_LOW_ACTIVE 1

`endif

//--- fd_stream_if.sv
`timescale 1ns/100ps

// Valid/ready stream, payload chosen per instance
interface fd_stream_if #(
	parameter type payload_t = fd_pkg::pixel_t
);

	logic     valid;
	logic     ready;
	// Marks the final beat of a frame
	logic     last;
	payload_t data;

	// Producer side
	modport src
	(
		output valid,
		output last,
		output data,
		input  ready
	);

	// Consumer side
	modport snk
	(
		input  valid,
		input  last,
		input  data,
		output ready
	);

endinterface

//--- fd_tile_accum.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module fd_tile_accum
(
	input  logic     s_clk,
	input  logic     rst_n,
	input  logic     soft_clear,
	fd_stream_if.snk pix,
	fd_stream_if.src score
);

	localparam int CNT_W = $clog2(`FD_TILE_PIXELS);

	logic [CNT_W-1:0] cnt;
	fd_pkg::score_t   sum;
	fd_pkg::score_t   sum_next;
	logic             pix_fire;
	logic             tile_end;
	logic             out_valid;
	logic             out_last;
	fd_pkg::score_t   out_data;

	// Stall only while a finished score waits downstream
	assign pix.ready = !(out_valid && !score.ready);
	assign pix_fire  = pix.valid && pix.ready;
	assign tile_end  = (cnt == CNT_W'(`FD_TILE_PIXELS - 1));
	assign sum_next  = sum + fd_pkg::score_t'(pix.data);

	// Running sum and pixel count
	always_ff @(posedge s_clk)
	begin
		if (!rst_n || soft_clear)
		begin
			sum <= '0;
			cnt <= '0;
		end
		else if (pix_fire)
		begin
			if (tile_end)
			begin
				// Restart at once so the next tile can fill
				sum <= '0;
				cnt <= '0;
			end
			else
			begin
				sum <= sum_next;
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Output register valid
	always_ff @(posedge s_clk)
	begin
		if (!rst_n || soft_clear)
			out_valid <= 1'b0;
		else if (pix_fire && tile_end)
			out_valid <= 1'b1;
		else if (score.ready)
			out_valid <= 1'b0;
	end

	// Score payload with frame tag from the tile's final pixel
	always_ff @(posedge s_clk)
	begin
		if (pix_fire && tile_end)
		begin
			out_data <= sum_next;
			out_last <= pix.last;
		end
	end

	assign score.valid = out_valid;
	assign score.data  = out_data;
	assign score.last  = out_last;

endmodule

//--- fd_tile_classify.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module fd_tile_classify
(
	input  logic            s_clk,
	input  logic            rst_n,
	input  logic            soft_clear,
	fd_stream_if.snk        score,
	input  fd_pkg::pixel_t  band_lo,
	input  fd_pkg::pixel_t  band_hi,
	output fd_pkg::result_t result
);

	localparam int TILE_SHIFT = $clog2(`FD_TILE_PIXELS);

	fd_pkg::pixel_t    mean;
	logic              in_band;
	logic              score_fire;
	fd_pkg::tile_idx_t tile_cnt;
	logic [7:0]        hits;
	fd_pkg::tile_idx_t first;
	logic              done;

	// Never stalls the accumulator
	assign score.ready = 1'b1;
	assign score_fire  = score.valid && score.ready;

	// Tile mean by shift, tile length is a power of two
	assign mean    = score.data[TILE_SHIFT +: 8];
	// Inclusive band
	assign in_band = (mean >= band_lo) && (mean <= band_hi);

	always_ff @(posedge s_clk)
	begin
		if (!rst_n || soft_clear)
		begin
			tile_cnt <= '0;
			hits     <= '0;
			first    <= 8'hFF;
			done     <= 1'b0;
		end
		// Result frozen once the frame is done
		else if (score_fire && !done)
		begin
			if (in_band)
			begin
				hits <= hits + 1'b1;
				// Only the first hit of the frame is kept
				if (first == 8'hFF)
					first <= tile_cnt;
			end
			if (score.last)
			begin
				done     <= 1'b1;
				tile_cnt <= '0;
			end
			else
			begin
				tile_cnt <= tile_cnt + 1'b1;
			end
		end
	end

	assign result.hits  = hits;
	assign result.first = first;
	assign result.done  = done;

endmodule

//--- flist.f
+incdir+.
fd_pkg.sv
fd_stream_if.sv
fd_host_bridge.sv
fd_tile_accum.sv
fd_tile_classify.sv
fd_seg7_display.sv
face_detection_ip.sv
tb_clock_gen.sv
tb_face_detection.sv

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
	output logic s_clk,
	output logic rst_n
);

	// 10 ns period
	initial
	begin
		s_clk = 1'b0;
		forever #5 s_clk = ~s_clk;
	end

	// Reset held for 10 cycles, released away from the rising edge
	initial
	begin
		rst_n = 1'b0;
		repeat (10) @(posedge s_clk);
		@(negedge s_clk);
		rst_n = 1'b1;
	end

endmodule

//--- tb_face_detection.sv
`timescale 1ns/100ps
`include "fd_settings.svh"

module tb_face_detection;

	localparam int MAX_REC = 16;
	localparam int NPIX    = `FD_FRAME_PIXELS;

	logic                         s_clk;
	logic                         rst_n;
	logic [`FD_ADDR_WIDTH-1:0]    s_address;
	logic                         s_read;
	logic                         s_write;
	logic [7:0]                   s_writedata;
	logic [7:0]                   s_readdata;
	logic [`FD_SEG7_DIGITS*8-1:0] seg7;

	// Golden records
	string      rec_name [MAX_REC];
	logic [7:0] rec_lo [MAX_REC];
	logic [7:0] rec_hi [MAX_REC];
	logic [7:0] rec_pix [MAX_REC][NPIX];
	logic [7:0] rec_hits [MAX_REC];
	logic [7:0] rec_first [MAX_REC];
	int         num_rec;
	logic       loaded;

	tb_clock_gen u_clk_gen
	(
		.s_clk (s_clk),
		.rst_n (rst_n)
	);

	face_detection_ip u_dut
	(
		.s_clk       (s_clk),
		.rst_n       (rst_n),
		.s_address   (s_address),
		.s_read      (s_read),
		.s_readdata  (s_readdata),
		.s_write     (s_write),
		.s_writedata (s_writedata),
		.SEG7        (seg7)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string test, input string field,
		input logic [15:0] expected, input logic [15:0] actual);
		assert (actual === expected)
		else
		begin
			$display("Error: %s %s expected %0h actual %0h", test, field, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Hex digit to segments, a at bit 0
	function automatic logic [6:0] seg_code(input logic [3:0] nib);
		logic [6:0] table_seg [16];
		table_seg = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
			7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
		return table_seg[nib];
	endfunction

	// Low-active display word, decimal point dark
	function automatic logic [`FD_SEG7_DIGITS*8-1:0] expected_seg7(input logic [7:0] hits);
		logic [`FD_SEG7_DIGITS*8-1:0] pat;
		logic [31:0]                  wide;
		wide = 32'(hits);
		for (int d = 0; d < `FD_SEG7_DIGITS; d++)
			pat[d*8 +: 8] = ~{1'b0, seg_code(wide[d*4 +: 4])};
		return pat;
	endfunction

	task automatic load_golden();
		int         fd;
		int         c;
		int         code;
		string      tok;
		fd = $fopen("fd_golden.txt", "r");
		if (fd == 0)
			abort_run("Could not open the golden file fd_golden.txt");
		num_rec = 0;
		while ($fscanf(fd, "%s", tok) == 1)
		begin
			if (tok[0] == "#")
			begin
				// Rest of a comment line
				c = $fgetc(fd);
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end
			else
			begin
				if (num_rec == MAX_REC)
					abort_run("The golden file holds more records than the testbench can store");
				rec_name[num_rec] = tok;
				code = $fscanf(fd, "%h %h", rec_lo[num_rec], rec_hi[num_rec]);
				for (int i = 0; i < NPIX; i++)
					code += $fscanf(fd, "%h", rec_pix[num_rec][i]);
				code += $fscanf(fd, "%h %h", rec_hits[num_rec], rec_first[num_rec]);
				if (code != NPIX + 4)
					abort_run("A record in the golden file is incomplete");
				num_rec++;
			end
		end
		$fclose(fd);
		if (num_rec == 0)
			abort_run("The golden file holds no records");
	endtask

	// Random 0 to 3 idle cycles between host accesses
	task automatic idle_gap();
		int n;
		n = $urandom % 4;
		repeat (n) @(negedge s_clk);
	endtask

	task automatic host_write(input fd_pkg::reg_addr_e addr, input logic [7:0] data);
		s_address   = addr;
		s_writedata = data;
		s_write     = 1'b1;
		@(negedge s_clk);
		s_write     = 1'b0;
		idle_gap();
	endtask

	task automatic host_read(input fd_pkg::reg_addr_e addr, output logic [7:0] data);
		s_address = addr;
		s_read    = 1'b1;
		@(negedge s_clk);
		s_read    = 1'b0;
		// Registered at the rising edge just passed
		data      = s_readdata;
		idle_gap();
	endtask

	task automatic read_check(input string test, input string field,
		input fd_pkg::reg_addr_e addr, input logic [7:0] expected);
		logic [7:0] rd;
		host_read(addr, rd);
		check_value(test, field, 16'(expected), 16'(rd));
	endtask

	task automatic send_pixels(input int r, input int n);
		for (int i = 0; i < n; i++)
			host_write(fd_pkg::REG_PIXEL, rec_pix[r][i]);
	endtask

	// Poll status until the done bit shows
	task automatic wait_done();
		logic [7:0] st;
		host_read(fd_pkg::REG_STATUS, st);
		while (!st[1])
			host_read(fd_pkg::REG_STATUS, st);
	endtask

	task automatic run_frame(input int r);
		string t;
		t = rec_name[r];
		host_write(fd_pkg::REG_BAND_LO, rec_lo[r]);
		host_write(fd_pkg::REG_BAND_HI, rec_hi[r]);
		read_check(t, "band_lo", fd_pkg::REG_BAND_LO, rec_lo[r]);
		read_check(t, "band_hi", fd_pkg::REG_BAND_HI, rec_hi[r]);
		host_write(fd_pkg::REG_CTRL, 8'h02);
		// Open, not done, dropped flag cleared by the start
		read_check(t, "status_open", fd_pkg::REG_STATUS, 8'h01);
		send_pixels(r, NPIX);
		wait_done();
		read_check(t, "status_done", fd_pkg::REG_STATUS, 8'h02);
		read_check(t, "hits", fd_pkg::REG_HITS, rec_hits[r]);
		read_check(t, "first", fd_pkg::REG_FIRST, rec_first[r]);
		check_value(t, "seg7", 16'(expected_seg7(rec_hits[r])), 16'(seg7));
	endtask

	// Watchdog, six cycles per pixel plus one spare frame for the abort test
	initial
	begin
		wait (loaded === 1'b1);
		#((num_rec + 1) * NPIX * 6 * 10 + 2000);
		$display("Timeout: the run did not finish and the results never arrived");
		$display("Simulation failed");
		$fatal(1);
	end

	initial
	begin
		s_address   = '0;
		s_read      = 1'b0;
		s_write     = 1'b0;
		s_writedata = '0;
		loaded      = 1'b0;
		void'($urandom(32'h80c2));
		load_golden();
		loaded = 1'b1;
		wait (rst_n === 1'b1);
		@(negedge s_clk);
		// Band registers out of reset
		read_check("reset", "band_lo", fd_pkg::REG_BAND_LO, 8'h00);
		read_check("reset", "band_hi", fd_pkg::REG_BAND_HI, 8'hFF);
		// Pixel with no open frame
		host_write(fd_pkg::REG_PIXEL, 8'h5A);
		read_check("stray_pixel", "status", fd_pkg::REG_STATUS, 8'h04);
		for (int r = 0; r < num_rec; r++)
			run_frame(r);
		// Soft reset on a finished frame drops done and results
		host_write(fd_pkg::REG_CTRL, 8'h01);
		read_check("soft_reset_done", "status", fd_pkg::REG_STATUS, 8'h00);
		read_check("soft_reset_done", "hits", fd_pkg::REG_HITS, 8'h00);
		read_check("soft_reset_done", "first", fd_pkg::REG_FIRST, 8'hFF);
		// Abort halfway, some tiles already scored
		host_write(fd_pkg::REG_BAND_LO, rec_lo[0]);
		host_write(fd_pkg::REG_BAND_HI, rec_hi[0]);
		host_write(fd_pkg::REG_CTRL, 8'h02);
		send_pixels(0, NPIX / 2 + 4);
		read_check("soft_reset_mid", "status_open", fd_pkg::REG_STATUS, 8'h01);
		host_write(fd_pkg::REG_CTRL, 8'h01);
		read_check("soft_reset_mid", "status", fd_pkg::REG_STATUS, 8'h00);
		read_check("soft_reset_mid", "hits", fd_pkg::REG_HITS, 8'h00);
		read_check("soft_reset_mid", "first", fd_pkg::REG_FIRST, 8'hFF);
		// Full frame after the abort
		run_frame(0);
		$display("Simulation passed");
		$finish;
	end

endmodule
